/* hdl/alu_params_pkg.sv */
// datapath widths only; ZSX_W and DBL_W follow ALU_W, so change ALU_W alone and keep it >= 2
package alu_params_pkg;

	// operand and result width of the integer datapath
	localparam int ALU_W = 32;

	// one extra msb for zero or sign extension of an operand
	// signed and unsigned then share one adder
	localparam int ZSX_W = ALU_W + 1;

	// double width, used when the high word of a result is asked for
	localparam int DBL_W = 2 * ALU_W;

	// ALU_W = 32 gives:
	//   ZSX_W = 33  extended operand
	//   DBL_W = 64  extended result, low word | high word
	//
	// the adder in alu_add_sub is ALU_W+2 wide.  that is one more bit than ZSX_W,
	// so sum and difference of two extended operands never overflow.
	// the high word of the double-width value is then only sign bits,
	// or the carry when the operation is unsigned

endpackage : alu_params_pkg

/* hdl/alu_op_pkg.sv */
// 3-bit opcode space is fully named; only X/Z or a forced cast reaches the decoder's illegal arm
package alu_op_pkg;

	localparam int OP_W = 3;  // opcode field width

	// add/subtract path operations
	// X forms return the high word of the double-width value
	// CMP forms subtract, return the low word, flags carry the result
	typedef enum logic [OP_W-1:0] {
		OP_ADD   = 3'd0,  // low word of a+b
		OP_SUB   = 3'd1,  // low word of a-b
		OP_ADDXU = 3'd2,  // high word, unsigned a+b
		OP_ADDXS = 3'd3,  // high word, signed a+b
		OP_SUBXU = 3'd4,  // high word, unsigned a-b
		OP_SUBXS = 3'd5,  // high word, signed a-b
		OP_CMPU  = 3'd6,  // unsigned compare
		OP_CMPS  = 3'd7   // signed compare
	} alu_op_e;

	// bit patterns worth knowing:
	//   ext forms sit at 2..5
	//   signed forms have bit 0 set, except OP_SUB
	// the decoder uses a full case instead, so the codes can be moved
	// without touching the logic

	// sub strobe is set for OP_SUB, OP_SUBXU, OP_SUBXS, OP_CMPU, OP_CMPS
	// sgn strobe is set for OP_ADDXS, OP_SUBXS, OP_CMPS

endpackage : alu_op_pkg

/* hdl/pipe.sv */
// DEPTH registers with async reset to RESET_VAL; DEPTH 0 is a plain wire and adds no cycle
module pipe #(
	parameter int unsigned          DEPTH     = 1,   // register stages, 0 = wire
	parameter int unsigned          WIDTH     = 8,   // data width
	parameter logic [WIDTH-1:0]     RESET_VAL = '0   // value after reset
) (
	input  logic                    clk_i,
	input  logic                    arst_n_i,       // async reset, active low
	input  logic [WIDTH-1:0]        data_i,
	output logic [WIDTH-1:0]        data_o
);

	generate
		if (DEPTH == 0) begin : g_wire
			// no stages, straight through
			assign data_o = data_i;
		end else begin : g_regs
			logic [WIDTH-1:0] stage_q [DEPTH];  // stage 0 nearest the input

			always_ff @(posedge clk_i or negedge arst_n_i) begin
				if (!arst_n_i) begin
					for (int i = 0; i < DEPTH; i++) begin
						stage_q[i] <= RESET_VAL;
					end
				end else begin
					stage_q[0] <= data_i;  // capture
					// shift along the chain
					for (int i = 1; i < DEPTH; i++) begin
						stage_q[i] <= stage_q[i-1];
					end
				end
			end

			assign data_o = stage_q[DEPTH-1];  // last stage drives out
		end
	endgenerate

endmodule : pipe

/* hdl/alu_op_decode.sv */
// purely combinational, zero cycles; non-member codes (X, Z) decode as ADD and raise illegal_o
module alu_op_decode (
	input  alu_op_pkg::alu_op_e     op_i,       // operation
	output logic                    sgn_o,      // 1 = signed extension
	output logic                    sub_o,      // 1 = subtract, 0 = add
	output logic                    ext_o,      // 1 = high word of result
	output logic                    illegal_o   // opcode not a member of alu_op_e
);

	always_comb begin
		// ADD controls unless a case arm says otherwise
		sgn_o     = 1'b0;
		sub_o     = 1'b0;
		ext_o     = 1'b0;
		illegal_o = 1'b0;

		unique case (op_i)
			alu_op_pkg::OP_ADD: begin
				// plain low-word add, defaults stand
			end
			alu_op_pkg::OP_SUB: begin
				sub_o = 1'b1;  // low-word subtract
			end
			alu_op_pkg::OP_ADDXU: begin
				ext_o = 1'b1;  // carry out in high word
			end
			alu_op_pkg::OP_ADDXS: begin
				sgn_o = 1'b1;
				ext_o = 1'b1;  // sign bits in high word
			end
			alu_op_pkg::OP_SUBXU: begin
				sub_o = 1'b1;
				ext_o = 1'b1;  // borrow shows as all ones
			end
			alu_op_pkg::OP_SUBXS: begin
				sgn_o = 1'b1;
				sub_o = 1'b1;
				ext_o = 1'b1;
			end
			alu_op_pkg::OP_CMPU: begin
				sub_o = 1'b1;  // flags unsigned
			end
			alu_op_pkg::OP_CMPS: begin
				sgn_o = 1'b1;  // flags signed
				sub_o = 1'b1;
			end
			default: begin
				// X or out-of-range code keeps the ADD controls
				illegal_o = 1'b1;
			end
		endcase
	end

	// resulting control table
	//   op      sgn sub ext
	//   ADD      0   0   0
	//   SUB      0   1   0
	//   ADDXU    0   0   1
	//   ADDXS    1   0   1
	//   SUBXU    0   1   1
	//   SUBXS    1   1   1
	//   CMPU     0   1   0
	//   CMPS     1   1   0

endmodule : alu_op_decode

/* hdl/alu_add_sub.sv */
// result after REGS_IN+REGS_MID+REGS_OUT edges, flags after REGS_IN+REGS_FLG; no overflow detect
module alu_add_sub #(
	parameter int unsigned REGS_IN  = 1,  // input register depth
	parameter int unsigned REGS_MID = 1,  // mid register depth
	parameter int unsigned REGS_OUT = 1,  // output register depth
	parameter int unsigned REGS_FLG = 1   // flag register depth
) (
	input  logic                              clk_i,
	input  logic                              arst_n_i,   // async reset, active low
	input  logic                              sgn_i,      // 1 = signed
	input  logic                              ext_i,      // 1 = high word
	input  logic                              sub_i,      // 1 = subtract
	input  logic [alu_params_pkg::ALU_W-1:0]  a_i,
	input  logic [alu_params_pkg::ALU_W-1:0]  b_i,
	output logic [alu_params_pkg::ALU_W-1:0]  result_o,   // a +/- b, low or high word
	output logic                              flg_ne_o,   // a != b
	output logic                              flg_lt_o    // a < b, under sgn rule
);

	localparam int ALU_W     = alu_params_pkg::ALU_W;
	localparam int ZSX_W     = alu_params_pkg::ZSX_W;
	localparam int DBL_W     = alu_params_pkg::DBL_W;
	localparam int ADD_SUB_W = ALU_W + 2;  // room for carry and sign

	logic                 sgn, sub, ext;         // after input stage
	logic [ALU_W-1:0]     a, b;
	logic [ZSX_W-1:0]     a_zsx, b_zsx;          // extended operands
	logic [ADD_SUB_W-1:0] ab_add, ab_sub;
	logic                 sub_m, ext_m;          // after mid stage
	logic [ADD_SUB_W-1:0] ab_add_m, ab_sub_m;
	logic [ADD_SUB_W-1:0] res_sel;               // chosen sum or difference
	logic [DBL_W-1:0]     res_dbl;               // sign extended to double width
	logic [ALU_W-1:0]     result;
	logic                 flg_ne, flg_lt;

	// controls and operands in
	pipe #(
		.DEPTH     (REGS_IN),
		.WIDTH     (3 + 2 * ALU_W),
		.RESET_VAL ('0)
	) u_in_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   ({sub_i, ext_i, sgn_i, b_i, a_i}),
		.data_o   ({sub,   ext,   sgn,   b,   a  })
	);

	// extension bit is msb when signed, else zero
	assign a_zsx = {sgn & a[ALU_W-1], a};
	assign b_zsx = {sgn & b[ALU_W-1], b};

	// both results at once, one more bit than the operands
	assign ab_add = {a_zsx[ZSX_W-1], a_zsx} + {b_zsx[ZSX_W-1], b_zsx};
	assign ab_sub = {a_zsx[ZSX_W-1], a_zsx} - {b_zsx[ZSX_W-1], b_zsx};

	assign flg_ne = (a != b);
	assign flg_lt = ab_sub[ADD_SUB_W-1];  // sign of the extended difference

	// flags leave early, they skip mid and out
	pipe #(
		.DEPTH     (REGS_FLG),
		.WIDTH     (2),
		.RESET_VAL ('0)
	) u_flg_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   ({flg_ne,   flg_lt  }),
		.data_o   ({flg_ne_o, flg_lt_o})
	);

	// break the adder from the muxes
	pipe #(
		.DEPTH     (REGS_MID),
		.WIDTH     (2 + 2 * ADD_SUB_W),
		.RESET_VAL ('0)
	) u_mid_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   ({sub,   ext,   ab_sub,   ab_add  }),
		.data_o   ({sub_m, ext_m, ab_sub_m, ab_add_m})
	);

	// sum or difference
	always_comb begin
		unique case (sub_m)
			1'b1:    res_sel = ab_sub_m;
			default: res_sel = ab_add_m;
		endcase
	end

	// high word is all sign bits, or the carry when unsigned
	assign res_dbl = {{(DBL_W - ADD_SUB_W){res_sel[ADD_SUB_W-1]}}, res_sel};

	// low or high word
	always_comb begin
		unique case (ext_m)
			1'b1:    result = res_dbl[DBL_W-1:ALU_W];
			default: result = res_dbl[ALU_W-1:0];
		endcase
	end

	pipe #(
		.DEPTH     (REGS_OUT),
		.WIDTH     (ALU_W),
		.RESET_VAL ('0)
	) u_out_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   (result),
		.data_o   (result_o)
	);

endmodule : alu_add_sub

/* hdl/alu_core.sv */
// one op per clock, no handshake or back-pressure; illegal_o shares the flag latency
module alu_core #(
	parameter int unsigned REGS_IN  = 1,  // input register depth
	parameter int unsigned REGS_MID = 1,  // mid register depth
	parameter int unsigned REGS_OUT = 1,  // output register depth
	parameter int unsigned REGS_FLG = 1   // flag register depth
) (
	input  logic                              clk_i,
	input  logic                              arst_n_i,   // async reset, active low
	input  alu_op_pkg::alu_op_e               op_i,       // sampled every edge
	input  logic [alu_params_pkg::ALU_W-1:0]  a_i,
	input  logic [alu_params_pkg::ALU_W-1:0]  b_i,
	output logic [alu_params_pkg::ALU_W-1:0]  result_o,
	output logic                              flg_ne_o,
	output logic                              flg_lt_o,
	output logic                              illegal_o   // opcode was not decodable
);

	logic sgn, sub, ext, illegal;  // decoder strobes

	// combinational, same cycle as op_i
	alu_op_decode u_decode (
		.op_i      (op_i),
		.sgn_o     (sgn),
		.sub_o     (sub),
		.ext_o     (ext),
		.illegal_o (illegal)
	);

	alu_add_sub #(
		.REGS_IN  (REGS_IN),
		.REGS_MID (REGS_MID),
		.REGS_OUT (REGS_OUT),
		.REGS_FLG (REGS_FLG)
	) u_add_sub (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.sgn_i    (sgn),
		.ext_i    (ext),
		.sub_i    (sub),
		.a_i      (a_i),
		.b_i      (b_i),
		.result_o (result_o),
		.flg_ne_o (flg_ne_o),
		.flg_lt_o (flg_lt_o)
	);

	// illegal strobe follows the flag path
	pipe #(
		.DEPTH     (REGS_IN + REGS_FLG),
		.WIDTH     (1),
		.RESET_VAL (1'b0)
	) u_illegal_pipe (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   (illegal),
		.data_o   (illegal_o)
	);

endmodule : alu_core

/* verification/alu_core_tb.sv */
// default depths only, result 3 edges and flags 2; X-opcode row needs a four-state simulator
module alu_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int W           = alu_params_pkg::ALU_W;
	localparam int DW          = alu_params_pkg::DBL_W;
	localparam int N_DIR       = 15;               // directed rows
	localparam int N_RAND      = 200;              // random rows
	localparam int RAND_TAG    = N_DIR;
	localparam int ILL_TAG     = N_DIR + 1;
	localparam int RESET_TAG   = N_DIR + 2;
	localparam int N_TAGS      = N_DIR + 3;
	localparam int TIMEOUT_CYC = 2 * (N_DIR + N_RAND + 3 + 4);
	localparam logic [31:0] SEED = 32'ha4dd_fcca;

	// one operation with its expected outputs
	typedef struct packed {
		alu_op_pkg::alu_op_e op;
		logic                xop;   // drive op as X
		logic [W-1:0]        a;
		logic [W-1:0]        b;
		logic [W-1:0]        res;
		logic                ne;
		logic                lt;
		logic                ill;
		int                  tag;   // -1 = drain filler
	} item_t;

	logic                clk_i;
	logic                arst_n_i;
	alu_op_pkg::alu_op_e op_i;
	logic [W-1:0]        a_i;
	logic [W-1:0]        b_i;
	logic [W-1:0]        result_o;
	logic                flg_ne_o;
	logic                flg_lt_o;
	logic                illegal_o;

	item_t items [$];   // stimulus table, applied in order
	item_t res_q [$];   // result delay line, 3 deep
	item_t flg_q [$];   // flag delay line, 2 deep
	string row_name [N_TAGS];
	int    tag_err  [N_TAGS];
	int    n_dir      = 0;
	int    rand_done  = 0;
	int    checks_cnt = 0;
	int    err_cnt    = 0;
	int    tests_cnt  = 0;
	int    tests_fail = 0;
	int    cycle_cnt  = 0;
	bit    reset_done = 1'b0;
	bit    four_state = 1'b0;

	alu_core dut (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.op_i      (op_i),
		.a_i       (a_i),
		.b_i       (b_i),
		.result_o  (result_o),
		.flg_ne_o  (flg_ne_o),
		.flg_lt_o  (flg_lt_o),
		.illegal_o (illegal_o)
	);

	always #5 clk_i = ~clk_i;  // 10 ns period

	// run limit from the table length
	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("run timed out after %0d cycles, outputs never drained", cycle_cnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// exact double-width arithmetic, no narrow adder
	task automatic calc_expected(input alu_op_pkg::alu_op_e op, input logic [W-1:0] a,
			input logic [W-1:0] b, output logic [W-1:0] res, output logic ne,
			output logic lt);
		logic          sgn;
		logic          sub;
		logic          ext;
		logic [DW-1:0] a_x;
		logic [DW-1:0] b_x;
		logic [DW-1:0] dif;
		logic [DW-1:0] r;
		sub = op inside {alu_op_pkg::OP_SUB, alu_op_pkg::OP_SUBXU, alu_op_pkg::OP_SUBXS,
			alu_op_pkg::OP_CMPU, alu_op_pkg::OP_CMPS};
		sgn = op inside {alu_op_pkg::OP_ADDXS, alu_op_pkg::OP_SUBXS, alu_op_pkg::OP_CMPS};
		ext = op inside {alu_op_pkg::OP_ADDXU, alu_op_pkg::OP_ADDXS, alu_op_pkg::OP_SUBXU,
			alu_op_pkg::OP_SUBXS};
		a_x = sgn ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
		b_x = sgn ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
		dif = a_x - b_x;
		r   = sub ? dif : a_x + b_x;
		res = ext ? r[DW-1:W] : r[W-1:0];
		ne  = (a != b);
		lt  = dif[DW-1];  // sign of the difference
	endtask

	task automatic push_item(input alu_op_pkg::alu_op_e op, input logic xop,
			input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] res,
			input logic ne, input logic lt, input logic ill, input int tag);
		item_t it;
		it.op  = op;
		it.xop = xop;
		it.a   = a;
		it.b   = b;
		it.res = res;
		it.ne  = ne;
		it.lt  = lt;
		it.ill = ill;
		it.tag = tag;
		items.push_back(it);
	endtask

	task automatic add_dir(input string name, input alu_op_pkg::alu_op_e op,
			input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] res,
			input logic ne, input logic lt);
		row_name[n_dir] = name;
		push_item(op, 1'b0, a, b, res, ne, lt, 1'b0, n_dir);
		n_dir++;
	endtask

	// directed rows, back to back with mixed opcodes
	task automatic build_table();
		// name, op, a, b, expected result, ne, lt
		add_dir("add", alu_op_pkg::OP_ADD, 32'h5, 32'h3, 32'h8, 1'b1, 1'b0);
		add_dir("add wrap", alu_op_pkg::OP_ADD, 32'hffff_ffff, 32'h1, 32'h0, 1'b1, 1'b0);
		add_dir("sub wrap", alu_op_pkg::OP_SUB, 32'h0, 32'h1, 32'hffff_ffff, 1'b1, 1'b1);
		add_dir("sub equal", alu_op_pkg::OP_SUB, 32'h7, 32'h7, 32'h0, 1'b0, 1'b0);
		add_dir("addxu", alu_op_pkg::OP_ADDXU, 32'hffff_ffff, 32'h1, 32'h1, 1'b1, 1'b0);
		add_dir("addxs", alu_op_pkg::OP_ADDXS, 32'hffff_ffff, 32'h1, 32'h0, 1'b1, 1'b1);
		add_dir("subxu", alu_op_pkg::OP_SUBXU, 32'h0, 32'h1, 32'hffff_ffff, 1'b1, 1'b1);
		add_dir("subxs", alu_op_pkg::OP_SUBXS, 32'h5, 32'h3, 32'h0, 1'b1, 1'b0);
		add_dir("cmpu min", alu_op_pkg::OP_CMPU, 32'h8000_0000, 32'h1, 32'h7fff_ffff, 1'b1, 1'b0);
		add_dir("cmps min", alu_op_pkg::OP_CMPS, 32'h8000_0000, 32'h1, 32'h7fff_ffff, 1'b1, 1'b1);
		add_dir("cmpu rev", alu_op_pkg::OP_CMPU, 32'h1, 32'h8000_0000, 32'h8000_0001, 1'b1, 1'b1);
		add_dir("cmps rev", alu_op_pkg::OP_CMPS, 32'h1, 32'h8000_0000, 32'h8000_0001, 1'b1, 1'b0);
		add_dir("cmps equal", alu_op_pkg::OP_CMPS, 32'h1234, 32'h1234, 32'h0, 1'b0, 1'b0);
		add_dir("addxs max", alu_op_pkg::OP_ADDXS, 32'h7fff_ffff, 32'h1, 32'h0, 1'b1, 1'b0);
		add_dir("subxs min", alu_op_pkg::OP_SUBXS, 32'h8000_0000, 32'h1, 32'hffff_ffff, 1'b1, 1'b1);
	endtask

	task automatic add_random();
		alu_op_pkg::alu_op_e op;
		logic [W-1:0]        a;
		logic [W-1:0]        b;
		logic [W-1:0]        res;
		logic                ne;
		logic                lt;
		row_name[RAND_TAG] = "random";
		for (int i = 0; i < N_RAND; i++) begin
			op = alu_op_pkg::alu_op_e'(3'($urandom));
			a  = $urandom;
			b  = ($urandom % 4 == 0) ? a : $urandom;  // some equal pairs for ne
			calc_expected(op, a, b, res, ne, lt);
			push_item(op, 1'b0, a, b, res, ne, lt, 1'b0, RAND_TAG);
		end
	endtask

	task automatic print_test(input int tag);
		tests_cnt++;
		if (tag_err[tag] == 0) begin
			$display("test %s: ok", row_name[tag]);
		end else begin
			tests_fail++;
			$display("test %s: failed with %0d mismatches", row_name[tag], tag_err[tag]);
		end
	endtask

	task automatic check_field(input string name, input logic [W-1:0] got,
			input logic [W-1:0] exp, input int tag);
		checks_cnt++;
		if (got !== exp) begin
			err_cnt++;
			if (tag >= 0) begin
				tag_err[tag]++;
			end
			$display("** Error at %0t: %s is %h, expected %h (%s)", $time, name, got, exp,
				(tag >= 0) ? row_name[tag] : "drain");
		end
	endtask

	task automatic check_reset();
		check_field("result_o", result_o, '0, RESET_TAG);
		check_field("flg_ne_o", W'(flg_ne_o), '0, RESET_TAG);
		check_field("flg_lt_o", W'(flg_lt_o), '0, RESET_TAG);
		check_field("illegal_o", W'(illegal_o), '0, RESET_TAG);
	endtask

	// called each falling edge, before the next op is driven
	task automatic check_outputs();
		item_t e;
		if (flg_q.size() == 2) begin
			e = flg_q.pop_front();  // op from two edges back
			check_field("flg_ne_o", W'(flg_ne_o), W'(e.ne), e.tag);
			check_field("flg_lt_o", W'(flg_lt_o), W'(e.lt), e.tag);
			check_field("illegal_o", W'(illegal_o), W'(e.ill), e.tag);
		end else begin
			// flag pipe still full of reset values
			check_field("flg_ne_o", W'(flg_ne_o), '0, RESET_TAG);
			check_field("flg_lt_o", W'(flg_lt_o), '0, RESET_TAG);
			check_field("illegal_o", W'(illegal_o), '0, RESET_TAG);
		end
		if (res_q.size() == 3) begin
			e = res_q.pop_front();
			if (!reset_done) begin
				reset_done = 1'b1;
				print_test(RESET_TAG);  // pipe fill done
			end
			check_field("result_o", result_o, e.res, e.tag);
			// result is the last field of an op
			if (e.tag == RAND_TAG) begin
				rand_done++;
				if (rand_done == N_RAND) begin
					print_test(RAND_TAG);
				end
			end else if (e.tag >= 0) begin
				print_test(e.tag);
			end
		end else begin
			check_field("result_o", result_o, '0, RESET_TAG);
		end
	endtask

	task automatic drive_item(input item_t it);
		if (it.xop) begin
			op_i = alu_op_pkg::alu_op_e'(3'bxxx);
		end else begin
			op_i = it.op;
		end
		a_i = it.a;
		b_i = it.b;
		res_q.push_back(it);
		flg_q.push_back(it);
	endtask

	initial begin
		logic         x_probe;
		logic [W-1:0] res;
		logic         ne;
		logic         lt;
		void'($urandom(SEED));
		clk_i    = 1'b0;
		arst_n_i = 1'b0;
		op_i     = alu_op_pkg::OP_SUBXU;  // all ones at the output if reset leaks
		a_i      = '0;
		b_i      = 32'h0000_0001;
		foreach (tag_err[i]) begin
			tag_err[i] = 0;
		end
		row_name[RESET_TAG] = "reset";
		x_probe    = 1'bx;
		four_state = $isunknown(x_probe);

		build_table();
		add_random();
		// every 3-bit code is named, so only X is out of range
		if (four_state) begin
			row_name[ILL_TAG] = "illegal opcode";
			calc_expected(alu_op_pkg::OP_ADD, 32'h0000_0010, 32'h0000_0020, res, ne, lt);
			push_item(alu_op_pkg::OP_ADD, 1'b1, 32'h0000_0010, 32'h0000_0020, res, ne, lt,
				1'b1, ILL_TAG);
		end else begin
			$display("illegal opcode: skipped, the simulator cannot hold an X opcode");
		end
		// fillers push the last real op out
		for (int i = 0; i < 3; i++) begin
			calc_expected(alu_op_pkg::OP_ADD, '0, '0, res, ne, lt);
			push_item(alu_op_pkg::OP_ADD, 1'b0, '0, '0, res, ne, lt, 1'b0, -1);
		end

		repeat (4) begin
			@(negedge clk_i);
			check_reset();
		end
		arst_n_i = 1'b1;

		for (int i = 0; i < items.size(); i++) begin
			check_outputs();
			drive_item(items[i]);
			@(negedge clk_i);
		end

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_cnt, tests_fail,
			checks_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule : alu_core_tb

/* list.f */
hdl/alu_params_pkg.sv
hdl/alu_op_pkg.sv
hdl/pipe.sv
hdl/alu_op_decode.sv
hdl/alu_add_sub.sv
hdl/alu_core.sv
verification/alu_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it; success needs the pass line in the output
cd "$(dirname "$0")" || exit 1

out="$(verilator --binary --timing -j 0 --top-module alu_core_tb -f list.f \
	-o alu_core_tb_sim && ./obj_dir/alu_core_tb_sim)" \
	|| { echo "$out"; echo "build or simulation failed"; exit 1; }

echo "$out"
grep -q "TEST RESULT: PASS" <<< "$out" && exit 0 || exit 1
